// ==== include/uart_config.svh ====
//----------------------------------------------------------
// build-time settings for the UART text transmitter
// UART_CLK_DIV must be 2 or more
// UART_VALUE_BITS above 9 overflows the three decimal digits
//----------------------------------------------------------
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// system clocks per serial bit
// kept small so a simulation run stays short
`define UART_CLK_DIV 4

// width of the binary value sent as text
// 8 bits gives 0..255, always printed as three digits
`define UART_VALUE_BITS 8

`endif

// ==== src/uartPkg.sv ====
//----------------------------------------------------------
// serial line protocol types, 8N1 framing only
// no parity and no second stop bit
//----------------------------------------------------------
`default_nettype none

package uartPkg;

    localparam int DATA_BITS = 8;   // data bits per frame

    // transmitter FSM
    typedef enum logic [2:0] {
        txIdle,
        txConvert,     // waiting on the decimal converter
        txLoad,        // one cycle, character into the shifter
        txStart,
        txData,
        txStop
    } txState_t;

    // level that the line register takes next
    typedef enum logic [1:0] {
        lineIdle,      // high
        lineStart,     // low
        lineData,      // current data bit
        lineStop       // high
    } lineSel_t;

endpackage

`default_nettype wire

// ==== src/fmtPkg.sv ====
//----------------------------------------------------------
// text format of one message
// three decimal digits with leading zeros, then a line feed
//----------------------------------------------------------
`default_nettype none

package fmtPkg;

    typedef logic [7:0] asciiChar_t;
    typedef logic [1:0] charIdx_t;     // 0..3 within a message
    typedef logic [3:0] bcdDigit_t;

    localparam int MSG_CHARS  = 4;             // digits plus line feed
    localparam int NUM_DIGITS = MSG_CHARS - 1;

    localparam asciiChar_t ASCII_ZERO = 8'h30;
    localparam asciiChar_t ASCII_LF   = 8'h0a;

endpackage

`default_nettype wire

// ==== src/baudTimer.sv ====
//----------------------------------------------------------
// bit period timer, one tick every UART_CLK_DIV clocks
// held at zero while timerRun is low, so the first tick
// after a restart always comes a full period later
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module baudTimer (
    input  wire  iSysClk,
    input  wire  arstN,
    input  wire  timerRun,
    output logic bitTick
);

    localparam int DIV_W = $clog2(`UART_CLK_DIV);
    localparam logic [DIV_W-1:0] LAST_CNT = DIV_W'(`UART_CLK_DIV - 1);

    logic [DIV_W-1:0] divCnt;

    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
            divCnt <= '0;
        else if (!timerRun || bitTick)
            divCnt <= '0;              // restart of frame or wrap
        else
            divCnt <= divCnt + 1'b1;
    end

    assign bitTick = timerRun && (divCnt == LAST_CNT);  // terminal count

endmodule

`default_nettype wire

// ==== src/decAsciiConv.sv ====
//----------------------------------------------------------
// binary to three ASCII decimal digits by double dabble
// one input bit per cycle, convDone UART_VALUE_BITS cycles
// after convStart; digits hold until the next convStart
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module decAsciiConv (
    input  wire                          iSysClk,
    input  wire                          arstN,
    input  wire                          convStart,
    input  wire [`UART_VALUE_BITS-1:0]   value,
    output logic                         convDone,
    input  wire fmtPkg::charIdx_t        charIdx,
    output fmtPkg::asciiChar_t           asciiChar
);

    import fmtPkg::*;

    localparam int VAL_W = `UART_VALUE_BITS;
    localparam int CNT_W = $clog2(VAL_W);
    localparam int DIG_W = 4 * NUM_DIGITS;
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(VAL_W - 1);

    logic             busy;
    logic [CNT_W-1:0] stepCnt;
    logic [VAL_W-1:0] binReg;    // bits still to shift in, msb first
    logic [DIG_W-1:0] bcdReg;    // hundreds in the top nibble
    logic [DIG_W-1:0] bcdAdj;
    bcdDigit_t        selDigit;

    //----------------------------------------------------------
    // step control
    //----------------------------------------------------------
    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
        begin
            busy    <= 1'b0;
            stepCnt <= '0;
        end
        else if (convStart)
        begin
            busy    <= 1'b1;
            stepCnt <= '0;
        end
        else if (busy)
        begin
            stepCnt <= stepCnt + 1'b1;
            if (stepCnt == LAST_STEP)
                busy <= 1'b0;
        end
    end

    assign convDone = busy && (stepCnt == LAST_STEP);  // last step this cycle

    //----------------------------------------------------------
    // shift and add-3
    //----------------------------------------------------------
    always_comb
    begin
        for (int d = 0; d < NUM_DIGITS; d++)
            bcdAdj[4*d +: 4] = (bcdReg[4*d +: 4] > 4'd4) ? bcdReg[4*d +: 4] + 4'd3
                                                          : bcdReg[4*d +: 4];
    end

    always_ff @(posedge iSysClk)
    begin
        if (convStart)
        begin
            binReg <= value;
            bcdReg <= '0;
        end
        else if (busy)
            {bcdReg, binReg} <= {bcdAdj[DIG_W-2:0], binReg, 1'b0};
    end

    // character select, index 0 is the hundreds digit
    always_comb
    begin
        selDigit = '0;
        for (int d = 0; d < NUM_DIGITS; d++)
            if (charIdx == charIdx_t'(d))
                selDigit = bcdReg[4*(NUM_DIGITS-1-d) +: 4];
        if (charIdx == charIdx_t'(MSG_CHARS - 1))
            asciiChar = ASCII_LF;
        else
            asciiChar = ASCII_ZERO + asciiChar_t'(selDigit);
    end

endmodule

`default_nettype wire

// ==== src/txShifter.sv ====
//----------------------------------------------------------
// character shift register and registered line output
// txLine trails lineSel by one clock and is high from reset
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module txShifter (
    input  wire                      iSysClk,
    input  wire                      arstN,
    input  wire                      load,
    input  wire                      shift,
    input  wire fmtPkg::asciiChar_t  loadChar,
    input  wire uartPkg::lineSel_t   lineSel,
    output logic                     txLine
);

    import uartPkg::*;
    import fmtPkg::*;

    asciiChar_t charReg;   // bit 0 is the current data bit

    always_ff @(posedge iSysClk)
    begin
        if (load)
            charReg <= loadChar;
        else if (shift)
            charReg <= {1'b1, charReg[7:1]};   // lsb first
    end

    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
            txLine <= 1'b1;
        else
        begin
            case (lineSel)
                lineStart: txLine <= 1'b0;
                lineData:  txLine <= charReg[0];
                default:   txLine <= 1'b1;     // idle and stop
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/txFsm.sv ====
//----------------------------------------------------------
// message sequencer: convert, then four 8N1 frames
// send is taken only while ready is high, ignored otherwise
// ready is low from the cycle after acceptance until the
// cycle after the last stop bit tick
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module txFsm (
    input  wire                 iSysClk,
    input  wire                 arstN,
    input  wire                 send,
    input  wire                 convDone,
    input  wire                 bitTick,
    output logic                convStart,
    output fmtPkg::charIdx_t    charIdx,
    output logic                load,
    output logic                shift,
    output uartPkg::lineSel_t   lineSel,
    output logic                timerRun,
    output logic                ready
);

    import uartPkg::*;
    import fmtPkg::*;

    localparam int BIT_W = $clog2(DATA_BITS);
    localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(DATA_BITS - 1);
    localparam charIdx_t         LAST_CHAR = charIdx_t'(MSG_CHARS - 1);

    txState_t         state;
    logic [BIT_W-1:0] dataCnt;
    charIdx_t         charCnt;

    //----------------------------------------------------------
    // state and counters
    //----------------------------------------------------------
    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
        begin
            state   <= txIdle;
            dataCnt <= '0;
            charCnt <= '0;
        end
        else
        begin
            case (state)
                txIdle:
                begin
                    if (send)
                    begin
                        state   <= txConvert;
                        charCnt <= '0;
                    end
                end
                txConvert:
                    if (convDone)
                        state <= txLoad;
                txLoad:
                begin
                    state   <= txStart;        // timer starts from zero here
                    dataCnt <= '0;
                end
                txStart:
                    if (bitTick)
                        state <= txData;
                txData:
                begin
                    if (bitTick)
                    begin
                        if (dataCnt == LAST_BIT)
                            state <= txStop;
                        else
                            dataCnt <= dataCnt + 1'b1;
                    end
                end
                txStop:
                begin
                    if (bitTick)
                    begin
                        if (charCnt == LAST_CHAR)
                            state <= txIdle;   // line feed was the last one
                        else
                        begin
                            charCnt <= charCnt + 1'b1;
                            state   <= txLoad;
                        end
                    end
                end
                default: state <= txIdle;
            endcase
        end
    end

    //----------------------------------------------------------
    // outputs, decoded from state
    //----------------------------------------------------------
    assign ready     = (state == txIdle);
    assign convStart = ready && send;
    assign load      = (state == txLoad);
    assign charIdx   = charCnt;
    assign timerRun  = (state == txStart) || (state == txData) || (state == txStop);

    // advance to the next bit, not after the last one
    assign shift = (state == txData) && bitTick && (dataCnt != LAST_BIT);

    always_comb
    begin
        case (state)
            txStart: lineSel = lineStart;
            txData:  lineSel = lineData;
            txStop:  lineSel = lineStop;
            default: lineSel = lineIdle;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/uartTxTop.sv ====
//----------------------------------------------------------
// UART transmitter that prints a value as decimal text
// send is a one-cycle pulse, dropped while ready is low
// each message is three digits and a line feed, 8N1
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uartTxTop (
    input  wire                          iSysClk,
    input  wire                          arstN,
    input  wire                          send,
    input  wire [`UART_VALUE_BITS-1:0]   value,
    output wire                          txLine,
    output wire                          ready
);

    import uartPkg::*;
    import fmtPkg::*;

    logic       convStart;
    logic       convDone;
    logic       bitTick;
    logic       timerRun;
    logic       load;
    logic       shift;
    charIdx_t   charIdx;
    asciiChar_t asciiChar;
    lineSel_t   lineSel;

    baudTimer timer_i (
        .iSysClk  (iSysClk),
        .arstN    (arstN),
        .timerRun (timerRun),
        .bitTick  (bitTick)
    );

    decAsciiConv conv_i (
        .iSysClk   (iSysClk),
        .arstN     (arstN),
        .convStart (convStart),
        .value     (value),
        .convDone  (convDone),
        .charIdx   (charIdx),
        .asciiChar (asciiChar)
    );

    txShifter shifter_i (
        .iSysClk  (iSysClk),
        .arstN    (arstN),
        .load     (load),
        .shift    (shift),
        .loadChar (asciiChar),
        .lineSel  (lineSel),
        .txLine   (txLine)
    );

    txFsm fsm_i (
        .iSysClk   (iSysClk),
        .arstN     (arstN),
        .send      (send),
        .convDone  (convDone),
        .bitTick   (bitTick),
        .convStart (convStart),
        .charIdx   (charIdx),
        .load      (load),
        .shift     (shift),
        .lineSel   (lineSel),
        .timerRun  (timerRun),
        .ready     (ready)
    );

endmodule

`default_nettype wire

// ==== verification/tbClkGen.sv ====
//----------------------------------------------------------
// testbench clock and reset, 100 ns clock period
// reset is low until the third rising edge
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbClkGen #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rstN
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial
    begin
        rstN <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/uartTxAssertions.sv ====
//----------------------------------------------------------
// concurrent checks on the transmitter, bound to uartTxTop
// FSM state comes from the fsm_i instance
// failCount is read by the testbench at the end of the run
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uartTxAssertions (
    input wire                     iSysClk,
    input wire                     arstN,
    input wire                     send,
    input wire                     txLine,
    input wire                     ready,
    input wire uartPkg::txState_t  state
);

    import uartPkg::*;

    localparam int FRAME_CYCLES = 10 * `UART_CLK_DIV;

    int lowCnt;             // cycles since ready fell
    int failCount = 0;

    always_ff @(posedge iSysClk or negedge arstN)
    begin
        if (!arstN)
            lowCnt <= 0;
        else if (ready)
            lowCnt <= 0;
        else
            lowCnt <= lowCnt + 1;
    end

    // idle line while the transmitter is free
    lineHighWhenReady: assert property (
        @(posedge iSysClk) disable iff (!arstN) ready |-> txLine)
    else
    begin
        $error("txLine low while ready is high");
        failCount++;
    end

    // an accepted send takes the FSM out of idle
    acceptLeavesIdle: assert property (
        @(posedge iSysClk) disable iff (!arstN) (ready && send) |=> (state == txConvert))
    else
    begin
        $error("FSM did not leave idle after an accepted send");
        failCount++;
    end

    busyAtLeastOneFrame: assert property (
        @(posedge iSysClk) disable iff (!arstN) $rose(ready) |-> (lowCnt >= FRAME_CYCLES))
    else
    begin
        $error("ready low for less than one frame");
        failCount++;
    end

endmodule

`default_nettype wire

// ==== verification/uartTxTb.sv ====
//----------------------------------------------------------
// testbench for the UART text transmitter
// reads verification/uart_stim.txt, run from the project root
// a software receiver decodes txLine at mid-bit
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uartTxTb;

    import fmtPkg::*;

    localparam int VW      = `UART_VALUE_BITS;
    localparam int DIV     = `UART_CLK_DIV;
    localparam int FRAME   = 10 * DIV;         // clocks per 8N1 frame
    localparam int MSG_LEN = 4;                // three digits and a line feed
    localparam asciiChar_t CH_ZERO = 8'h30;
    localparam asciiChar_t CH_LF   = 8'h0a;

    logic          iSysClk;
    logic          arstN;
    logic          send;
    logic [VW-1:0] value;
    wire           txLine;
    wire           ready;

    int          stimVal[$];
    int          stimGap[$];
    asciiChar_t  expQ[$];                      // characters still owed by the DUT
    bit          stimLoaded  = 1'b0;
    int          errCount    = 0;
    int          errAtStart  = 0;
    int          rxCount     = 0;
    int          testsRun    = 0;
    int          testsFailed = 0;
    logic [31:0] rngState    = 32'hd197546c;

    tbClkGen clkGen_i (
        .clk  (iSysClk),
        .rstN (arstN)
    );

    uartTxTop dut_i (
        .iSysClk (iSysClk),
        .arstN   (arstN),
        .send    (send),
        .value   (value),
        .txLine  (txLine),
        .ready   (ready)
    );

    bind uartTxTop uartTxAssertions asrt_i (
        .iSysClk (iSysClk),
        .arstN   (arstN),
        .send    (send),
        .txLine  (txLine),
        .ready   (ready),
        .state   (fsm_i.state)
    );

    //----------------------------------------------------------
    // helpers
    //----------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int nextRand(input int range);
        rngState = xorshift32(rngState);
        return int'(rngState % 32'(range));
    endfunction

    // decimal digits with leading zeros, then line feed
    task automatic expectMessage(input int v);
        expQ.push_back(CH_ZERO + asciiChar_t'(v / 100));
        expQ.push_back(CH_ZERO + asciiChar_t'((v / 10) % 10));
        expQ.push_back(CH_ZERO + asciiChar_t'(v % 10));
        expQ.push_back(CH_LF);
    endtask

    task automatic logMismatch(input string name, input logic [31:0] expv,
                               input logic [31:0] gotv);
        $display("ERR t=%0t %s expected %0h got %0h", $time, name, expv, gotv);
        errCount++;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errCount != errAtStart)
        begin
            testsFailed++;
            $display("test %s: failed, %0d errors", name, errCount - errAtStart);
        end
        else
            $display("test %s: ok", name);
        errAtStart = errCount;
    endtask

    //----------------------------------------------------------
    // receiver, samples on the falling clock edge
    //----------------------------------------------------------
    initial
    begin : receiver
        asciiChar_t rxChar;
        asciiChar_t expChar;
        @(posedge arstN);
        forever
        begin
            @(negedge iSysClk);
            if (txLine === 1'b0)
            begin
                repeat (DIV / 2) @(negedge iSysClk);  // middle of start bit
                if (txLine !== 1'b0)
                begin
                    $display("frame error at %0t: start bit did not stay low", $time);
                    errCount++;
                end
                for (int i = 0; i < 8; i++)
                begin
                    repeat (DIV) @(negedge iSysClk);
                    rxChar[i] = txLine;                // lsb first
                end
                repeat (DIV) @(negedge iSysClk);
                if (txLine !== 1'b1)
                begin
                    $display("frame error at %0t: stop bit was low", $time);
                    errCount++;
                end
                rxCount++;
                if (expQ.size() == 0)
                begin
                    $display("unexpected character %0h on txLine at %0t", rxChar, $time);
                    errCount++;
                end
                else
                begin
                    expChar = expQ.pop_front();
                    if (rxChar !== expChar)
                        logMismatch("txLine char", 32'(expChar), 32'(rxChar));
                end
            end
        end
    end

    initial
    begin : watchdog
        int limit;
        wait (stimLoaded);
        limit = stimVal.size() * (4 * FRAME + 64) + 200;  // cycles of 100 ns
        repeat (limit) @(posedge iSysClk);
        $display("timeout: run did not end within %0d clock cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

    //----------------------------------------------------------
    // stimulus
    //----------------------------------------------------------
    initial
    begin : stimulus
        int    fd;
        int    v;
        int    g;
        int    rxBefore;
        string line;
        send  <= 1'b0;
        value <= '0;
        fd = $fopen("verification/uart_stim.txt", "r");
        if (fd == 0)
            $display("could not open verification/uart_stim.txt");
        else
        begin
            while ($fgets(line, fd) != 0)
                if ($sscanf(line, "%d %d", v, g) == 2)   // comment lines do not parse
                begin
                    stimVal.push_back(v);
                    stimGap.push_back(g);
                end
            $fclose(fd);
        end
        if (stimVal.size() == 0)
        begin
            $display("no stimulus entries were read");
            errCount++;
        end
        stimLoaded = 1'b1;

        @(posedge arstN);
        @(negedge iSysClk);
        if (txLine !== 1'b1)
            logMismatch("txLine", 32'd1, 32'(txLine));
        if (ready !== 1'b1)
            logMismatch("ready", 32'd1, 32'(ready));
        repeat (2 * DIV) @(negedge iSysClk);
        if (txLine !== 1'b1)
            logMismatch("txLine", 32'd1, 32'(txLine));
        endTest("reset");

        foreach (stimVal[k])
        begin
            while (ready !== 1'b1)
                @(negedge iSysClk);
            if (stimGap[k] > 0)                        // gap 0 sends at once
                repeat (stimGap[k] + nextRand(4)) @(negedge iSysClk);
            expectMessage(stimVal[k]);
            rxBefore = rxCount;
            @(posedge iSysClk);
            send  <= 1'b1;
            value <= VW'(stimVal[k]);
            @(posedge iSysClk);
            send  <= 1'b0;
            @(negedge iSysClk);
            if (ready !== 1'b0)
                logMismatch("ready", 32'd0, 32'(ready));

            // second send while busy, must be dropped
            repeat (1 + nextRand(100)) @(negedge iSysClk);
            if (ready === 1'b0)
            begin
                @(posedge iSysClk);
                send  <= 1'b1;
                value <= ~value;
                @(posedge iSysClk);
                send  <= 1'b0;
            end
            while (ready !== 1'b1)
                @(negedge iSysClk);
            if (rxCount - rxBefore != MSG_LEN)
                logMismatch("chars before ready", 32'(MSG_LEN), 32'(rxCount - rxBefore));
            endTest($sformatf("message %0d value %0d", k, stimVal[k]));
        end

        repeat (2 * FRAME) @(negedge iSysClk);
        if (expQ.size() != 0)
        begin
            $display("%0d expected characters never appeared on txLine", expQ.size());
            errCount++;
        end
        if (dut_i.asrt_i.failCount != 0)
        begin
            $display("%0d assertion failures during the run", dut_i.asrt_i.failCount);
            errCount++;
        end
        endTest("drain");
        $display("summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errCount);
        if (errCount == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
src/uartPkg.sv
src/fmtPkg.sv
src/baudTimer.sv
src/decAsciiConv.sv
src/txShifter.sv
src/txFsm.sv
src/uartTxTop.sv
verification/tbClkGen.sv
verification/uartTxAssertions.sv
verification/uartTxTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the UART text transmitter testbench with Verilator
# call from anywhere, paths are relative to the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module uartTxTb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# keep running after an assertion error so the testbench reports it
./obj_dir/VuartTxTb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1

// ==== verification/uart_stim.txt ====
# columns: value (decimal, 0..255) then idle gap in clock cycles before the send
# gap 0 sends as soon as ready is seen high again
0 5
9 0
100 3
255 0
42 0
7 12
199 0
250 8
1 0
99 2
128 0
63 20
200 1
10 0
